/* src.f */
+incdir+common
common/fetch_pkg.sv
hw/pc_gen.sv
icache/icache.sv
hw/mem_arbiter.sv
hw/axi_rd_master.sv
hw/fetch_top.sv
tests/tb_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the fetch testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fetch --Mdir "$OBJ_DIR" -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_fetch" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -qx "Testbench passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* tests/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch
  import fetch_pkg::*;
();

  localparam int          EXP_FETCHES = 200;  // rough total over all phases
  localparam int          MAX_CYCLES  = EXP_FETCHES * 200 + 1000;
  localparam logic [63:0] LOOP_PC     = 64'h0000_0000_8000_1000;

  logic       clk = 1'b0;
  logic       rst_n;
  redirect_t  redirect;
  logic       stall;
  fetch_out_t fetch_o;
  data_req_t  data_req;
  data_rsp_t  data_rsp;
  axi_ar_t    ar;
  logic       ar_ready = 1'b0;
  axi_r_t     r_in = '0;
  logic       r_ready;

  integer      seed = 25;
  int          fetch_cnt;
  int          data_rsp_cnt;
  int          fetch_ar_cnt;
  int          data_req_cnt = 0;
  logic [63:0] exp_pc;
  logic [63:0] data_addr;
  logic        prev_stall;
  fetch_out_t  prev_fetch;
  fetch_out_t  exp_f;
  data_rsp_t   exp_d;
  axi_ar_t     ar_fifo[$];   // accepted bursts served in order
  logic [7:0]  r_beat;
  int          r_gap = 0;

  always #4 clk = ~clk;

  fetch_top u_fetch_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect),
    .stall_i    (stall),
    .fetch_o    (fetch_o),
    .data_req_i (data_req),
    .data_rsp_o (data_rsp),
    .ar_o       (ar),
    .ar_ready_i (ar_ready),
    .r_i        (r_in),
    .r_ready_o  (r_ready)
  );

  // memory contents as a hash over the whole 8-byte aligned address
  function automatic logic [63:0] mem_word(input logic [63:0] addr);
    logic [31:0] mix;
    mix = addr[63:32] ^ {addr[31:3], 3'b000} ^ 32'h5a5a_0f0f;
    return {mix * 32'h9e37_79b1, mix ^ {addr[18:3], addr[34:19]}};
  endfunction

  function automatic logic [31:0] ref_inst(input logic [63:0] pc);
    logic [63:0] word;
    word = mem_word({pc[63:3], 3'b000});
    return pc[2] ? word[63:32] : word[31:0];  // pc bit 2 picks the half
  endfunction

  task automatic report_error(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      report_error($sformatf("fetch v%0b pc %h inst %h, expected v%0b pc %h inst %h",
                             got.valid, got.pc, got.inst, exp.valid, exp.pc, exp.inst));
    end
  endtask

  task automatic check_data(input data_rsp_t got, input data_rsp_t exp);
    if (got !== exp) begin
      report_error($sformatf("data read %h returned %h, expected %h",
                             data_addr, got.data, exp.data));
    end
  endtask

  // slave memory with random AR ready and random gaps before each R beat
  always @(posedge clk) begin
    if (!rst_n) begin
      ar_ready     <= 1'b0;
      r_in         <= '0;
      r_beat       <= '0;
      fetch_ar_cnt <= 0;
    end else begin
      ar_ready <= ($random(seed) & 3) != 0;
      if (ar.valid && ar_ready) begin
        ar_fifo.push_back(ar);
        if (ar.id == ID_FETCH) begin
          fetch_ar_cnt <= fetch_ar_cnt + 1;
          if (ar.len != 8'd1 || ar.addr[3:0] != 4'h0 || ar.size != 3'd3) begin
            report_error($sformatf("refill AR at %h is not an aligned 2-beat burst", ar.addr));
          end
        end else if (ar.id != ID_DATA || ar.len != 8'd0 || ar.size != 3'd3 ||
                     ar.addr != {data_addr[63:3], 3'b000}) begin
          report_error($sformatf("data AR id %0d addr %h, request was %h",
                                 ar.id, ar.addr, data_addr));
        end
      end
      if (r_in.valid && r_ready) begin
        r_in.valid <= 1'b0;
        r_beat     <= r_in.last ? 8'd0 : r_beat + 8'd1;
        if (r_in.last) void'(ar_fifo.pop_front());
        r_gap = $random(seed) & 3;
      end else if (!r_in.valid && ar_fifo.size() > 0) begin
        if (r_gap > 0) begin
          r_gap = r_gap - 1;
        end else begin
          r_in.valid <= 1'b1;
          r_in.data  <= mem_word(ar_fifo[0].addr + {53'd0, r_beat, 3'b000});
          r_in.id    <= ar_fifo[0].id;
          r_in.resp  <= 2'b00;
          r_in.last  <= (r_beat == ar_fifo[0].len);
        end
      end
    end
  end

  // compare process tracking the pc the fetch stream must deliver next
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc       <= `RESET_PC;
      fetch_cnt    <= 0;
      data_rsp_cnt <= 0;
      prev_stall   <= 1'b0;
      prev_fetch   <= '0;
    end else begin
      prev_stall <= stall;
      prev_fetch <= fetch_o;
      if (!fetch_o.valid && fetch_o.inst !== `NOP_INST) begin
        report_error($sformatf("invalid fetch shows %h instead of the NOP", fetch_o.inst));
      end
      if (redirect.valid) begin
        if (fetch_o.valid) report_error("fetch valid in the same cycle as a redirect");
        exp_pc <= redirect.target;
      end else if (fetch_o.valid) begin
        exp_f.valid = 1'b1;
        exp_f.pc    = exp_pc;
        exp_f.inst  = ref_inst(exp_pc);
        check_fetch(fetch_o, exp_f);
        if (!stall) begin
          exp_pc    <= exp_pc + 64'd4;
          fetch_cnt <= fetch_cnt + 1;
        end
      end
      if (stall && prev_stall && prev_fetch.valid) check_fetch(fetch_o, prev_fetch);
      if (data_rsp.valid) begin
        exp_d.valid = 1'b1;
        exp_d.data  = mem_word({data_addr[63:3], 3'b000});
        check_data(data_rsp, exp_d);
        data_rsp_cnt <= data_rsp_cnt + 1;
      end
    end
  end

  task automatic redirect_to(input logic [63:0] target);
    redirect <= {1'b1, target};
    @(posedge clk);
    redirect <= '0;
  endtask

  task automatic wait_pc(input logic [63:0] pc);
    @(posedge clk);
    while (!(fetch_o.valid && fetch_o.pc == pc)) @(posedge clk);
  endtask

  // a data read goes out in each miss cycle with nothing in flight
  task automatic fetch_with_reads(input int n);
    int          target;
    logic [63:0] addr;
    target = fetch_cnt + n;
    while (fetch_cnt < target) begin
      @(posedge clk);
      data_req <= '0;
      if (!fetch_o.valid && data_req_cnt == data_rsp_cnt) begin
        addr = {$random(seed), $random(seed)};
        data_req  <= {1'b1, addr};
        data_addr <= addr;
        data_req_cnt++;
      end
    end
    @(posedge clk);
    data_req <= '0;
  endtask

  initial begin
    int ar_before;
    rst_n     <= 1'b0;
    stall     <= 1'b0;
    redirect  <= '0;
    data_req  <= '0;
    data_addr <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (fetch_o.valid || ar.valid || fetch_o.pc !== `RESET_PC) begin
      report_error("fetch or AR valid after reset, or pc not at the reset vector");
    end
    while (fetch_cnt < 64) @(posedge clk);
    // freeze while the cache hits
    while (!fetch_o.valid) @(posedge clk);
    stall <= 1'b1;
    repeat (6) @(posedge clk);
    stall <= 1'b0;
    while (fetch_cnt < 80) @(posedge clk);
    // the second pass over an eight instruction loop must not refill
    redirect_to(LOOP_PC);
    wait_pc(LOOP_PC + 64'd28);
    redirect_to(LOOP_PC);
    ar_before = fetch_ar_cnt;
    wait_pc(LOOP_PC + 64'd28);
    if (fetch_ar_cnt != ar_before) report_error("second pass over the loop issued a refill");
    redirect_to(LOOP_PC + 64'd4);
    wait_pc(LOOP_PC + 64'd8);
    redirect_to(LOOP_PC + 64'd20);  // lands while the next pc would hit
    wait_pc(LOOP_PC + 64'd20);
    for (int i = 0; i < 6; i++) begin
      redirect_to(64'h8000_0000 + ({32'd0, $random(seed)} & 64'h000f_fffc));
      fetch_with_reads(16);
    end
    while (data_rsp_cnt != data_req_cnt) @(posedge clk);
    if (data_req_cnt > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_error("no data read was issued during the cache misses");
    end
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  redirect_t redirect_i,
  input  wire logic stall_i,
  output fetch_out_t fetch_o,
  input  data_req_t data_req_i,
  output data_rsp_t data_rsp_o,
  output axi_ar_t   ar_o,
  input  wire logic ar_ready_i,
  input  axi_r_t    r_i,
  output logic      r_ready_o
);

  logic [63:0] pc;
  logic        hit;
  mem_req_t    refill_req;
  mem_req_t    rd_req;
  logic        rd_idle;
  beat_t       rd_beat;
  beat_t       refill_beat;

  pc_gen u_pc_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .stall_i    (stall_i),
    .hit_i      (hit),
    .pc_o       (pc)
  );

  icache u_icache (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .redirect_i   (redirect_i),
    .hit_o        (hit),
    .fetch_o      (fetch_o),
    .refill_req_o (refill_req),
    .beat_i       (refill_beat)
  );

  // data reads from the memory stage share the one read port
  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .refill_req_i  (refill_req),
    .data_req_i    (data_req_i),
    .rd_idle_i     (rd_idle),
    .rd_req_o      (rd_req),
    .beat_i        (rd_beat),
    .refill_beat_o (refill_beat),
    .data_rsp_o    (data_rsp_o)
  );

  axi_rd_master u_axi_rd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (rd_req),
    .idle_o     (rd_idle),
    .ar_o       (ar_o),
    .ar_ready_i (ar_ready_i),
    .r_i        (r_i),
    .r_ready_o  (r_ready_o),
    .beat_o     (rd_beat)
  );

endmodule

`default_nettype wire

/* hw/axi_rd_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module axi_rd_master
  import fetch_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  mem_req_t  req_i,
  output logic      idle_o,
  output axi_ar_t   ar_o,
  input  wire logic ar_ready_i,
  input  axi_r_t    r_i,
  output logic      r_ready_o,
  output beat_t     beat_o
);

  localparam logic [2:0] BEAT_SIZE = 3'($clog2(`XLEN / 8));  // 8 bytes per beat

  rd_state_e        state_q;
  logic [`XLEN-1:0] addr_q;
  axi_id_e          id_q;
  logic [7:0]       beats_q;
  logic             r_take;

  assign idle_o    = (state_q == RD_IDLE);
  assign r_ready_o = (state_q == RD_DATA);
  assign r_take    = r_ready_o && r_i.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      unique case (state_q)
        RD_IDLE: if (req_i.valid) state_q <= RD_ADDR;
        RD_ADDR: if (ar_ready_i) state_q <= RD_DATA;
        RD_DATA: if (r_take && r_i.last) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // request fields, captured once and held until the burst ends
  always_ff @(posedge clk) begin
    if (idle_o && req_i.valid) begin
      addr_q  <= req_i.addr;
      id_q    <= req_i.id;
      beats_q <= req_i.beats;
    end
  end

  always_comb begin
    ar_o.valid = (state_q == RD_ADDR);
    ar_o.addr  = addr_q;
    ar_o.id    = id_q;
    ar_o.len   = beats_q - 8'd1;
    ar_o.size  = BEAT_SIZE;
  end

  always_comb begin
    beat_o.valid = r_take;
    beat_o.data  = r_i.data;
    beat_o.id    = id_q;       // tag with the requester we issued for
    beat_o.last  = r_i.last;
  end

  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ar_o.valid && !ar_ready_i) |=> (ar_o.valid && $stable(ar_o))
  ) else $error("axi_rd_master: AR changed before handshake");

  // slave must answer in order with the id we sent
  a_r_id_match: assert property (
    @(posedge clk) disable iff (!rst_n)
    r_take |-> (r_i.id == id_q) && (r_i.resp == 2'b00)
  ) else $error("axi_rd_master: unexpected R id or error response");

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module mem_arbiter
  import fetch_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  mem_req_t  refill_req_i,
  input  data_req_t data_req_i,
  input  wire logic rd_idle_i,
  output mem_req_t  rd_req_o,
  input  beat_t     beat_i,
  output beat_t     refill_beat_o,
  output data_rsp_t data_rsp_o
);

  logic             data_pend_q;
  logic [`XLEN-1:0] data_addr_q;
  logic             data_grant;
  logic             data_beat;

  assign data_grant = rd_idle_i && data_pend_q;   // data read has priority
  assign data_beat  = beat_i.valid && (beat_i.id == ID_DATA);

  always_comb begin
    rd_req_o = '0;
    if (data_grant) begin
      rd_req_o.valid = 1'b1;
      rd_req_o.addr  = {data_addr_q[`XLEN-1:3], 3'b000}; // single 8-byte beat
      rd_req_o.id    = ID_DATA;
      rd_req_o.beats = 8'd1;
    end else if (rd_idle_i && refill_req_i.valid) begin
      rd_req_o = refill_req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_pend_q <= 1'b0;
    end else begin
      if (data_grant) data_pend_q <= 1'b0;
      if (data_req_i.valid) data_pend_q <= 1'b1;  // new strobe wins
    end
  end

  always_ff @(posedge clk) begin
    if (data_req_i.valid) data_addr_q <= data_req_i.addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_rsp_o <= '0;
    end else begin
      data_rsp_o.valid <= data_beat;    // one-cycle pulse
      if (data_beat) data_rsp_o.data <= beat_i.data;
    end
  end

  // refill beats go straight through so the line fills on the R edge
  always_comb begin
    refill_beat_o       = beat_i;
    refill_beat_o.valid = beat_i.valid && (beat_i.id == ID_FETCH);
  end

endmodule

`default_nettype wire

/* icache/icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module icache
  import fetch_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic [`XLEN-1:0] pc_i,
  input  redirect_t         redirect_i,
  output logic              hit_o,
  output fetch_out_t        fetch_o,
  output mem_req_t          refill_req_o,
  input  beat_t             beat_i
);

  localparam int OFF_W  = $clog2(`IC_BEATS * 8); // byte offset in a line
  localparam int IDX_W  = $clog2(`IC_LINES);
  localparam int TAG_W  = `XLEN - IDX_W - OFF_W;
  localparam int BSEL_W = $clog2(`IC_BEATS);

  ic_state_e state_q;

  logic [`IC_LINES-1:0] valid_q;
  logic [TAG_W-1:0]     tag_q  [`IC_LINES];
  logic [`XLEN-1:0]     line_q [`IC_LINES][`IC_BEATS];

  logic [`XLEN-1:0]     fill_addr_q;  // aligned line address of the miss
  logic [BSEL_W-1:0]    beat_cnt_q;

  logic [IDX_W-1:0]     pc_idx;
  logic [TAG_W-1:0]     pc_tag;
  logic [BSEL_W-1:0]    pc_beat;
  logic [IDX_W-1:0]     fill_idx;
  logic [TAG_W-1:0]     fill_tag;
  logic [`XLEN-1:0]     rd_beat;
  logic [`INST_W-1:0]   rd_word;
  logic                 line_hit;
  logic                 miss_start;
  logic                 fill_beat;
  logic                 fill_last;

  assign pc_idx   = pc_i[OFF_W +: IDX_W];
  assign pc_tag   = pc_i[`XLEN-1 -: TAG_W];
  assign pc_beat  = pc_i[OFF_W-1:3];
  assign fill_idx = fill_addr_q[OFF_W +: IDX_W];
  assign fill_tag = fill_addr_q[`XLEN-1 -: TAG_W];

  assign line_hit = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign rd_beat  = line_q[pc_idx][pc_beat];
  assign rd_word  = pc_i[2] ? rd_beat[63:32] : rd_beat[31:0]; // low half first

  // no hits while a line is being rewritten
  assign hit_o      = (state_q == IC_LOOKUP) && line_hit;
  // pc is about to change on a redirect, so that miss does not count
  assign miss_start = (state_q == IC_LOOKUP) && !line_hit && !redirect_i.valid;
  assign fill_beat  = (state_q == IC_REFILL) && beat_i.valid;
  assign fill_last  = fill_beat && beat_i.last;

  always_comb begin
    fetch_o.valid = hit_o && !redirect_i.valid;
    fetch_o.pc    = pc_i;
    fetch_o.inst  = fetch_o.valid ? rd_word : `NOP_INST;
  end

  always_comb begin
    refill_req_o.valid = (state_q == IC_REFILL);
    refill_req_o.addr  = fill_addr_q;
    refill_req_o.id    = ID_FETCH;
    refill_req_o.beats = 8'(`IC_BEATS);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IC_LOOKUP;
      beat_cnt_q <= '0;
      valid_q    <= '0;
    end else begin
      unique case (state_q)
        IC_LOOKUP: begin
          if (miss_start) begin
            state_q    <= IC_REFILL;
            beat_cnt_q <= '0;
          end
        end
        IC_REFILL: begin
          if (fill_beat) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
          if (fill_last) begin
            valid_q[fill_idx] <= 1'b1;  // tag lands in the same edge
            state_q           <= IC_LOOKUP;
          end
        end
        default: state_q <= IC_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      fill_addr_q <= {pc_i[`XLEN-1:OFF_W], {OFF_W{1'b0}}};
    end
    if (fill_beat) begin
      line_q[fill_idx][beat_cnt_q] <= beat_i.data;
    end
    if (fill_last) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

  a_no_valid_in_refill: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == IC_REFILL) |-> !fetch_o.valid
  ) else $error("icache: fetch valid during refill");

  // request must not wander before the arbiter and master finish with it
  a_refill_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (refill_req_o.valid && !fill_last) |=> (refill_req_o.valid && $stable(refill_req_o))
  ) else $error("icache: refill request changed while waiting");

endmodule

`default_nettype wire

/* hw/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  redirect_t             redirect_i,
  input  wire logic             stall_i,
  input  wire logic             hit_i,
  output logic [`XLEN-1:0]      pc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_d;
  logic             advance;

  // only move on when the cache actually delivered this pc
  assign advance = hit_i & ~stall_i;

  always_comb begin
    pc_d = pc_q;                       // hold by default
    if (redirect_i.valid) begin
      pc_d = redirect_i.target;        // redirect beats stall and advance
    end else if (advance) begin
      pc_d = pc_q + `XLEN'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // targets come from the execute stage, so check alignment here
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00
  ) else $error("pc_gen: misaligned pc %h", pc_q);

endmodule

`default_nettype wire

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  `include "fetch_consts.svh"

  // requester tags on the read port
  typedef enum logic [3:0] {
    ID_NONE  = 4'd0,
    ID_FETCH = 4'd1,
    ID_DATA  = 4'd2
  } axi_id_e;

  typedef enum logic {
    IC_LOOKUP,
    IC_REFILL
  } ic_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  target;
  } redirect_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
  } fetch_out_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;
    axi_id_e          id;
    logic [7:0]       beats; // burst length in beats, not axi len
  } mem_req_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;
  } data_req_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] data;
  } data_rsp_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;
    axi_id_e          id;
    logic [7:0]       len;  // beats minus one
    logic [2:0]       size;
  } axi_ar_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] data;
    axi_id_e          id;
    logic [1:0]       resp;
    logic             last;
  } axi_r_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] data;
    axi_id_e          id;
    logic             last;
  } beat_t;

endpackage

`default_nettype wire

/* common/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// bus and instruction widths
`define XLEN      64
`define INST_W    32

// direct mapped icache, 16 lines of 2 x 64-bit beats
`define IC_LINES  16
`define IC_BEATS  2

// boot address
`define RESET_PC  64'h0000_0000_8000_0000

// addi x0, x0, 0
`define NOP_INST  32'h0000_0013

`endif
